/* dv/ray_box_stim.txt */
# ox oy oz  ix iy iz  par  lo_x lo_y lo_z  hi_x hi_y hi_z  hit tnear tfar  note
# all numbers hex, Q8.8 except par (bit 0 is x) and hit
0000 0000 0000 0100 0100 0100 0 0100 0100 0100 0300 0300 0300 1 0100 0300 basic_hit
0400 0000 0000 ff00 0200 0080 0 0100 0100 0100 0300 0300 0300 0 0200 0180 mixed_miss
0400 0500 0000 ff00 ff00 0100 0 0100 0100 0100 0300 0300 0300 1 0200 0300 mixed_hit
0000 0000 0000 0100 0100 0100 0 0100 0200 0000 0200 0300 0400 1 0200 0200 graze
0500 0000 0000 ff00 0100 0100 0 0100 0400 ff00 0300 0600 0800 1 0400 0400 graze_neg
0080 0000 0000 0200 0100 0100 0 0100 0000 0040 0200 0280 0400 1 0100 0280 fraction
0001 0000 0000 0080 0100 0100 0 0000 ff00 ff00 0101 0100 0100 1 ffff 0080 trunc
0200 0000 0000 7fff 0100 0100 1 0100 0100 0200 0300 0300 0500 1 0200 0300 par_inside
0000 0500 0000 0100 0000 0100 2 0100 0100 0100 0300 0300 0300 0 0100 0300 par_outside_hi
0000 0000 fe00 0100 0100 0000 4 0100 0100 ff00 0300 0300 0100 0 0100 0300 par_outside_lo
0200 0200 0200 0000 0000 0000 7 0100 0100 0100 0300 0300 0300 1 8000 7fff par_all
0100 0000 0000 0000 0100 0100 1 0100 0100 0100 0300 0300 0300 1 0100 0300 par_on_plane
0500 0500 0500 0100 0100 0100 0 0100 0100 0100 0300 0300 0300 0 fc00 fe00 behind
0300 0300 0300 0100 0100 0100 0 0100 0100 0100 0300 0300 0300 0 fe00 0000 touch_zero
0000 0000 0000 ff00 ff00 ff00 0 0100 0100 0100 0300 0300 0300 0 fd00 ff00 behind_neg
8000 0000 0000 7fff 0100 0100 0 7f00 0000 0000 7fff 0100 0100 0 7fff 0100 sat_pos_miss
0000 0000 0000 7fff 0100 0100 0 ff00 ff00 ff00 7f00 0100 0100 1 ff00 0100 sat_pos_hit
0000 0000 0000 7fff 0100 0100 0 8000 ff00 fe00 0100 0200 0300 1 ff00 0200 sat_neg_hit
0000 0000 0000 8000 0100 0100 0 0200 ff00 ff00 7f00 0100 0100 0 ff00 8000 sat_neg_swap
7f00 0000 0000 8000 0100 0100 0 8000 0000 0000 0000 0100 0100 0 7fff 0100 guard_bit
0000 0000 0000 0100 0100 0100 0 0100 0300 0000 0200 0400 0500 0 0300 0200 side_miss
0200 0200 0200 0100 ff00 0100 0 0100 0100 0100 0300 0300 0300 1 ff00 0100 inside
0000 0000 0000 0080 0080 0080 0 0100 0200 0300 0400 0500 0600 1 0180 0200 half_inv
0000 0000 0000 0000 0100 0100 0 0100 0100 0100 0300 0300 0300 0 0100 0000 zero_inv

/* verilog.f */
source/ray_box_pkg.sv
source/slab_axis.sv
source/slab_bank.sv
source/span_reduce.sv
source/hit_resolve.sv
source/ray_box_top.sv
dv/ray_box_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ray/box testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_log=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f verilog.f --top-module ray_box_tb \
	-Mdir "$build_dir" -o ray_box_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

"./$build_dir/ray_box_sim" > "$sim_log" 2>&1
sim_status=$?

if grep -q "TEST FAILED" "$sim_log"; then
	echo "simulation reported a failure, see $sim_log"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status, see $sim_log"
	exit 1
fi
echo "simulation finished without failures"
exit 0

/* dv/ray_box_tb.sv */
module ray_box_tb import ray_box_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam string       STIM_FILE   = "dv/ray_box_stim.txt";
	localparam int          DRAIN_LIMIT = RAY_LAT + 4; // cycles allowed for the tail
	localparam logic [15:0] LFSR_SEED   = 16'd53657;
	localparam logic [15:0] LFSR_TAPS   = 16'hB400;    // x^16 + x^14 + x^13 + x^11 + 1

	logic        clk;
	logic        rst;
	logic        in_valid;
	ray_t        ray;
	box_t        box;
	logic        result_valid;
	ray_result_t result;

	ray_box_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.ray          (ray),
		.box          (box),
		.result_valid (result_valid),
		.result       (result)
	);

	always #2 clk = ~clk; // 4 ns period

	int cycle = 0;

	always @(posedge clk)
		cycle <= cycle + 1;

	// vectors from the stim file
	ray_t            stim_ray[$];
	box_t            stim_box[$];
	ray_result_t     stim_exp[$];
	logic [8*24-1:0] stim_note[$];

	// results in flight, oldest first
	ray_result_t     exp_q[$];
	int              exp_cycle_q[$];
	logic [8*24-1:0] exp_note_q[$];

	logic [15:0] lfsr_state = LFSR_SEED;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// one LFSR step per bit
	task automatic random_bits(input int n, output int val);
		val = 0;
		for (int k = 0; k < n; k++) begin
			val        = (val << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_hit(input logic got, input logic exp, input logic [8*24-1:0] note);
		if (got !== exp)
			report_failure($sformatf("Fail result.hit: got 0x%h expected 0x%h (%0s)",
				got, exp, note));
	endtask

	task automatic check_span(input ray_result_t got, input ray_result_t exp,
		input logic [8*24-1:0] note);
		if (got.tnear !== exp.tnear)
			report_failure($sformatf("Fail result.tnear: got 0x%h expected 0x%h (%0s)",
				got.tnear, exp.tnear, note));
		if (got.tfar !== exp.tfar)
			report_failure($sformatf("Fail result.tfar: got 0x%h expected 0x%h (%0s)",
				got.tfar, exp.tfar, note));
	endtask

	task automatic read_stim();
		int              fd;
		int              n;
		string           line;
		logic [15:0]     ox, oy, oz, ix, iy, iz, par;
		logic [15:0]     lx, ly, lz, hx, hy, hz;
		logic [15:0]     hit, tn, tf;
		logic [8*24-1:0] note;
		ray_t            r;
		box_t            b;
		ray_result_t     e;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			report_failure("could not open the stimulus file");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue; // blank or column notes
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s",
				ox, oy, oz, ix, iy, iz, par, lx, ly, lz, hx, hy, hz, hit, tn, tf, note);
			if (n != 17)
				report_failure($sformatf("malformed stimulus line: %s", line));
			r.origin   = '{ox, oy, oz};
			r.inv_dir  = '{ix, iy, iz};
			r.parallel = par[2:0];
			b.lo       = '{lx, ly, lz};
			b.hi       = '{hx, hy, hz};
			e          = '{hit[0], tn, tf};
			stim_ray.push_back(r);
			stim_box.push_back(b);
			stim_exp.push_back(e);
			stim_note.push_back(note);
		end
		$fclose(fd);
		if (stim_ray.size() == 0)
			report_failure("the stimulus file holds no vectors");
	endtask

	//////////////////////////////////////////////////
	// result checker
	//////////////////////////////////////////////////

	always @(posedge clk) begin : check_results
		int              lat;
		ray_result_t     exp_r;
		logic [8*24-1:0] note;
		if (rst) begin
			if (result_valid !== 1'b0)
				report_failure("result_valid was high during reset");
		end else if (result_valid !== 1'b0) begin
			if (result_valid !== 1'b1)
				report_failure("result_valid is unknown after reset");
			if (exp_q.size() == 0)
				report_failure("result_valid was high with no result outstanding");
			exp_r = exp_q.pop_front();
			note  = exp_note_q.pop_front();
			lat   = cycle - exp_cycle_q.pop_front(); // issue to sample
			if (lat != RAY_LAT)
				report_failure($sformatf("result for %0s came after %0d cycles instead of %0d",
					note, lat, RAY_LAT));
			check_hit(result.hit, exp_r.hit, note);
			check_span(result, exp_r, note);
		end else if (exp_q.size() > 0 && cycle - exp_cycle_q[0] >= RAY_LAT) begin
			report_failure($sformatf("no result appeared for %0s", exp_note_q[0]));
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin : run_test
		int gaps;
		int waited;
		clk      = 1'b0;
		rst      = 1'b0;
		in_valid = 1'b0;
		ray      = '0;
		box      = '0;
		read_stim();
		#0.5;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#0.5;
		rst = 1'b0;
		for (int i = 0; i < stim_ray.size(); i++) begin
			// two runs go back to back, the rest get 0 to 3 idle cycles
			if ((i >= 8 && i < 14) || i >= 18)
				gaps = 0;
			else
				random_bits(2, gaps);
			repeat (gaps) begin
				@(posedge clk);
				#0.5;
				in_valid = 1'b0;
			end
			@(posedge clk);
			#0.5;
			in_valid = 1'b1;
			ray      = stim_ray[i];
			box      = stim_box[i];
			exp_q.push_back(stim_exp[i]);
			exp_cycle_q.push_back(cycle);
			exp_note_q.push_back(stim_note[i]);
		end
		@(posedge clk);
		#0.5;
		in_valid = 1'b0;
		waited   = 0;
		while (exp_q.size() > 0) begin
			@(posedge clk);
			#0.5;
			waited++;
			if (waited > DRAIN_LIMIT)
				report_failure("timed out waiting for the last results");
		end
		repeat (RAY_LAT + 2) @(posedge clk); // watch for a stray result_valid
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* source/ray_box_top.sv */
module ray_box_top import ray_box_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  ray_t        ray,
	input  box_t        box,
	output logic        result_valid,
	output ray_result_t result
);

	logic             span_valid;
	axis_span_t [2:0] spans;     // per-axis entry/exit
	logic             red_valid;
	axis_span_t       red_span;  // tnear/tfar pair

	slab_bank slab_bank_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.ray        (ray),
		.box        (box),
		.span_valid (span_valid),
		.spans      (spans)
	);

	span_reduce span_reduce_i (
		.clk        (clk),
		.rst        (rst),
		.span_valid (span_valid),
		.spans      (spans),
		.red_valid  (red_valid),
		.red_span   (red_span)
	);

	hit_resolve hit_resolve_i (
		.clk          (clk),
		.rst          (rst),
		.red_valid    (red_valid),
		.red_span     (red_span),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

/* source/hit_resolve.sv */
module hit_resolve import ray_box_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        red_valid,
	input  axis_span_t  red_span,
	output logic        result_valid,
	output ray_result_t result
);

	logic hit_c;

	// box in front of the origin and interval not empty
	assign hit_c = !red_span.outside
		&& (red_span.tmax >= red_span.tmin)
		&& (red_span.tmax > 0);

	always_ff @(posedge clk) begin
		result.hit   <= hit_c;
		result.tnear <= red_span.tmin;
		result.tfar  <= red_span.tmax;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			result_valid <= 1'b0;
		else
			result_valid <= red_valid;
	end

endmodule

/* source/span_reduce.sv */
module span_reduce import ray_box_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             span_valid,
	input  axis_span_t [2:0] spans,
	output logic             red_valid,
	output axis_span_t       red_span
);

	// largest entry, smallest exit, either outside
	function automatic axis_span_t merge(input axis_span_t a, input axis_span_t b);
		axis_span_t m;
		m.tmin    = (a.tmin > b.tmin) ? a.tmin : b.tmin;
		m.tmax    = (a.tmax < b.tmax) ? a.tmax : b.tmax;
		m.outside = a.outside | b.outside;
		return m;
	endfunction

	//////////////////////////////////////////////////
	// stage 1: x against y, z carried
	//////////////////////////////////////////////////

	axis_span_t xy_q, z_q;

	always_ff @(posedge clk) begin
		xy_q <= merge(spans[0], spans[1]);
		z_q  <= spans[2];
	end

	//////////////////////////////////////////////////
	// stage 2: tnear and tfar
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		red_span <= merge(xy_q, z_q); // tmin is tnear, tmax is tfar
	end

	logic [REDUCE_LAT-1:0] vld_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[REDUCE_LAT-2:0], span_valid};
	end

	assign red_valid = vld_q[REDUCE_LAT-1];

endmodule

/* source/slab_bank.sv */
module slab_bank import ray_box_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  ray_t             ray,
	input  box_t             box,
	output logic             span_valid,
	output axis_span_t [2:0] spans
);

	// index 0 is x, matching ray.parallel
	fix_t [2:0] org, inv, lo, hi;

	assign org = {ray.origin.z, ray.origin.y, ray.origin.x};
	assign inv = {ray.inv_dir.z, ray.inv_dir.y, ray.inv_dir.x};
	assign lo  = {box.lo.z, box.lo.y, box.lo.x};
	assign hi  = {box.hi.z, box.hi.y, box.hi.x};

	for (genvar a = 0; a < 3; a++) begin : g_axis
		slab_axis axis_i (
			.clk      (clk),
			.origin   (org[a]),
			.inv      (inv[a]),
			.lo       (lo[a]),
			.hi       (hi[a]),
			.parallel (ray.parallel[a]),
			.span     (spans[a])
		);
	end

	logic [SLAB_LAT-1:0] vld_q; // valid beside the slab stages

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[SLAB_LAT-2:0], in_valid};
	end

	assign span_valid = vld_q[SLAB_LAT-1];

endmodule

/* source/slab_axis.sv */
module slab_axis import ray_box_pkg::*; (
	input  logic       clk,
	input  fix_t       origin,
	input  fix_t       inv,
	input  fix_t       lo,
	input  fix_t       hi,
	input  logic       parallel,
	output axis_span_t span
);

	// shift the raw product back to Q8.8 and clamp it
	function automatic fix_t sat_prod(input logic signed [2*FIX_W:0] prod);
		logic signed [2*FIX_W:0] shifted;
		shifted = prod >>> FRAC_BITS;
		if (shifted > T_POS_LIMIT)
			return T_POS_LIMIT;
		else if (shifted < T_NEG_LIMIT)
			return T_NEG_LIMIT;
		return fix_t'(shifted);
	endfunction

	logic signed [FIX_W:0] diff_lo, diff_hi; // one guard bit
	logic                  off_slab;

	assign diff_lo  = lo - origin;
	assign diff_hi  = hi - origin;
	assign off_slab = (origin < lo) || (origin > hi);

	//////////////////////////////////////////////////
	// stage 1: differences
	//////////////////////////////////////////////////

	logic signed [FIX_W:0] diff_lo_q, diff_hi_q;
	fix_t                  inv_q;
	logic                  par_q, out_q;

	always_ff @(posedge clk) begin
		diff_lo_q <= diff_lo;
		diff_hi_q <= diff_hi;
		inv_q     <= inv;
		par_q     <= parallel;
		out_q     <= parallel && off_slab; // only meaningful when parallel
	end

	//////////////////////////////////////////////////
	// stage 2: saturated products
	//////////////////////////////////////////////////

	logic signed [2*FIX_W:0] prod_lo, prod_hi;

	assign prod_lo = diff_lo_q * inv_q;
	assign prod_hi = diff_hi_q * inv_q;

	fix_t d_lo_q, d_hi_q;
	logic neg_q, par_qq, out_qq;

	always_ff @(posedge clk) begin
		d_lo_q <= sat_prod(prod_lo);
		d_hi_q <= sat_prod(prod_hi);
		neg_q  <= inv_q[FIX_W-1]; // negative direction
		par_qq <= par_q;
		out_qq <= out_q;
	end

	//////////////////////////////////////////////////
	// stage 3: ordered span
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (par_qq) begin
			span.tmin <= T_NEG_LIMIT; // slab never bounds the ray
			span.tmax <= T_POS_LIMIT;
		end else if (neg_q) begin
			span.tmin <= d_hi_q; // ray enters through the hi plane
			span.tmax <= d_lo_q;
		end else begin
			span.tmin <= d_lo_q;
			span.tmax <= d_hi_q;
		end
		span.outside <= out_qq;
	end

endmodule

/* source/ray_box_pkg.sv */
package ray_box_pkg;

	//////////////////////////////////////////////////
	// number format
	//////////////////////////////////////////////////

	localparam int FIX_W     = 16; // word width
	localparam int FRAC_BITS = 8;  // Q8.8

	typedef logic signed [FIX_W-1:0] fix_t;

	localparam fix_t T_NEG_LIMIT = fix_t'({1'b1, {(FIX_W-1){1'b0}}}); // -128.0
	localparam fix_t T_POS_LIMIT = fix_t'({1'b0, {(FIX_W-1){1'b1}}}); // just under +128.0

	//////////////////////////////////////////////////
	// pipeline depths
	//////////////////////////////////////////////////

	localparam int SLAB_LAT   = 3; // slab_bank
	localparam int REDUCE_LAT = 2; // span_reduce
	localparam int HIT_LAT    = 1; // hit_resolve
	localparam int RAY_LAT    = SLAB_LAT + REDUCE_LAT + HIT_LAT;

	//////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	typedef struct packed {
		vec3_t      origin;
		vec3_t      inv_dir;  // reciprocal direction
		logic [2:0] parallel; // bit 0 is x
	} ray_t;

	typedef struct packed {
		vec3_t lo; // lower corner
		vec3_t hi; // upper corner
	} box_t;

	typedef struct packed {
		fix_t tmin;
		fix_t tmax;
		logic outside; // parallel and origin off the slab
	} axis_span_t;

	typedef struct packed {
		logic hit;
		fix_t tnear;
		fix_t tfar;
	} ray_result_t;

endpackage
